/* include/fetch_config.svh */
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// first fetch address out of reset
`define RESET_PC 64'h8000_0000

// addi x0, x0, 0
`define NOP_INST 32'h0000_0013

// cache geometry
`define LINE_BEATS 4      // 64-bit beats per line
`define CACHE_LINES 16    // direct mapped, one way

// derived widths in bits
`define IDX_W $clog2(`CACHE_LINES)
`define OFF_W ($clog2(`LINE_BEATS) + 3)    // beat select plus byte in beat

`endif

/* source/fetch_pkg.sv */
`include "fetch_config.svh"

package fetch_pkg;

  // instruction address
  typedef logic [63:0] pc_t;

  // one fetched instruction
  typedef logic [31:0] inst_t;

  // one memory beat, also one cache data word
  typedef logic [63:0] word_t;

  // pc bits above index and line offset
  typedef logic [63-`IDX_W-`OFF_W:0] tag_t;

  // i_cache control
  typedef enum logic [1:0] {
    IDLE,       // waiting for a request
    LOOKUP,     // tag compare on the captured pc
    REFILL,     // line on its way from memory
    FILL_DONE   // answer from the freshly filled line
  } cache_state_e;

endpackage

/* source/axi_rd_pkg.sv */
package axi_rd_pkg;

  // AR and R channel field types
  typedef logic [7:0] axi_len_t;    // beats minus one
  typedef logic [2:0] axi_size_t;   // log2 of bytes per beat
  typedef logic [1:0] axi_burst_t;
  typedef logic [1:0] axi_resp_t;
  typedef logic [3:0] axi_id_t;

  // refill master control
  typedef enum logic [1:0] {
    AR_IDLE,   // no line in flight
    AR_SEND,   // address valid, waiting for ar_ready
    R_RECV     // collecting data beats
  } refill_state_e;

  localparam axi_burst_t AXI_BURST_INCR = 2'b01;
  localparam axi_size_t AXI_SIZE_8B = 3'b011;   // 8 bytes per beat

endpackage

/* source/fetch_ifs.sv */
`timescale 1ns/10ps

// pc_gen <-> i_cache, one request in flight at a time
interface fetch_req_if;
  import fetch_pkg::*;

  logic  req_valid;   // single cycle pulse
  pc_t   req_pc;
  logic  rsp_valid;   // one pulse per request
  inst_t rsp_inst;

  modport requester (output req_valid, output req_pc, input rsp_valid, input rsp_inst);
  modport responder (input req_valid, input req_pc, output rsp_valid, output rsp_inst);
endinterface

// i_cache <-> axi_refill_master, one line per fill_req
interface refill_if;
  import fetch_pkg::*;

  logic  fill_req;     // single cycle pulse
  pc_t   fill_addr;    // line aligned
  logic  beat_valid;   // one per received beat, address order
  word_t beat_data;
  logic  fill_done;    // cycle after the last beat

  modport cache (
    output fill_req, output fill_addr,
    input beat_valid, input beat_data, input fill_done
  );
  modport master (
    input fill_req, input fill_addr,
    output beat_valid, output beat_data, output fill_done
  );
endinterface

/* source/pc_gen.sv */
`timescale 1ns/10ps
`include "fetch_config.svh"

module pc_gen (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             redirect_i,
  input  fetch_pkg::pc_t   redirect_pc_i,
  input  logic             stall_i,
  output fetch_pkg::inst_t inst_o,
  output fetch_pkg::pc_t   pc_o,
  output logic             inst_valid_o,
  fetch_req_if.requester   fetch
);
  import fetch_pkg::*;

  pc_t   fetch_pc_q;   // pc of the outstanding or shown fetch
  pc_t   next_pc;
  logic  pending_q;    // request sent, no response yet
  logic  drop_q;       // outstanding request belongs to the old path
  inst_t inst_q;
  pc_t   pc_q;
  logic  valid_q;
  logic  accept;
  logic  rsp_keep;

  // decode takes the shown instruction
  assign accept = valid_q & ~stall_i;
  assign next_pc = accept ? fetch_pc_q + 64'd4 : fetch_pc_q;

  // response from the current path, not killed this cycle
  assign rsp_keep = fetch.rsp_valid & ~drop_q & ~redirect_i;

  // pending is never set while an instruction is shown,
  // so an accept always frees the slot for the next request
  assign fetch.req_valid = ~pending_q & (~valid_q | accept) & ~redirect_i;
  assign fetch.req_pc = next_pc;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fetch_pc_q <= `RESET_PC;
      pending_q <= 1'b0;
      drop_q <= 1'b0;
    end else begin
      if (redirect_i) begin
        fetch_pc_q <= redirect_pc_i;   // target goes out with the next request
      end else begin
        fetch_pc_q <= next_pc;
      end
      if (fetch.req_valid) begin
        pending_q <= 1'b1;
      end else if (fetch.rsp_valid) begin
        pending_q <= 1'b0;
      end
      if (redirect_i) begin
        drop_q <= pending_q & ~fetch.rsp_valid;   // still waiting on an old-path fetch
      end else if (fetch.rsp_valid) begin
        drop_q <= 1'b0;
      end
    end
  end

  // instruction register toward decode
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      inst_q <= `NOP_INST;
      pc_q <= `RESET_PC;
      valid_q <= 1'b0;
    end else if (redirect_i) begin
      inst_q <= `NOP_INST;   // kill whatever is shown
      valid_q <= 1'b0;
    end else if (rsp_keep) begin
      inst_q <= fetch.rsp_inst;
      pc_q <= fetch_pc_q;
      valid_q <= 1'b1;
    end else if (fetch.rsp_valid) begin
      inst_q <= `NOP_INST;   // dropped response
    end else if (accept) begin
      inst_q <= `NOP_INST;
      valid_q <= 1'b0;
    end
  end

  assign inst_o = inst_q;
  assign pc_o = pc_q;
  assign inst_valid_o = valid_q;

  // a stalled instruction stays put until decode takes it
  a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
    inst_valid_o && stall_i && !redirect_i |=>
      inst_valid_o && $stable(inst_o) && $stable(pc_o));

endmodule

/* source/i_cache.sv */
`timescale 1ns/10ps
`include "fetch_config.svh"

module i_cache (
  input  logic           clk,
  input  logic           rst_n,
  fetch_req_if.responder fetch,
  refill_if.cache        refill
);
  import fetch_pkg::*;

  localparam int BEAT_W = `OFF_W - 3;          // beat select inside a line
  localparam int TAG_LSB = `IDX_W + `OFF_W;

  cache_state_e state_q;
  cache_state_e state_d;
  pc_t          pc_q;   // pc under lookup and through refill

  tag_t                    tag_mem [`CACHE_LINES];
  logic [`CACHE_LINES-1:0] valid_q;
  word_t                   data_mem [`CACHE_LINES*`LINE_BEATS];

  logic [`IDX_W-1:0] line_idx;
  tag_t              pc_tag;
  logic [BEAT_W-1:0] beat_sel;
  logic [BEAT_W-1:0] fill_cnt_q;   // next beat slot to write
  logic              hit;
  word_t             rd_word;

  // address split
  assign line_idx = pc_q[TAG_LSB-1:`OFF_W];
  assign pc_tag = pc_q[63:TAG_LSB];
  assign beat_sel = pc_q[`OFF_W-1:3];

  assign hit = valid_q[line_idx] && (tag_mem[line_idx] == pc_tag);
  assign rd_word = data_mem[{line_idx, beat_sel}];

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (fetch.req_valid) begin
          state_d = LOOKUP;
        end
      end
      LOOKUP: begin
        state_d = hit ? IDLE : REFILL;   // miss goes to memory
      end
      REFILL: begin
        if (refill.fill_done) begin
          state_d = FILL_DONE;
        end
      end
      FILL_DONE: begin
        state_d = IDLE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  // hit answers in LOOKUP and a miss the cycle after fill_done
  assign fetch.rsp_valid = ((state_q == LOOKUP) && hit) || (state_q == FILL_DONE);
  assign fetch.rsp_inst = pc_q[2] ? rd_word[63:32] : rd_word[31:0];   // upper or lower half

  // whole line requested on a miss
  assign refill.fill_req = (state_q == LOOKUP) && !hit;
  assign refill.fill_addr = {pc_q[63:`OFF_W], {`OFF_W{1'b0}}};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      valid_q <= '0;
      fill_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      if (refill.fill_req) begin
        valid_q[line_idx] <= 1'b0;   // line is being replaced
        fill_cnt_q <= '0;
      end else if (refill.beat_valid) begin
        fill_cnt_q <= fill_cnt_q + 1'b1;
      end
      if (refill.fill_done) begin
        valid_q[line_idx] <= 1'b1;
      end
    end
  end

  // arrays and captured pc
  always_ff @(posedge clk) begin
    if (state_q == IDLE && fetch.req_valid) begin
      pc_q <= fetch.req_pc;
    end
    if (refill.fill_req) begin
      tag_mem[line_idx] <= pc_tag;
    end
    if (refill.beat_valid) begin
      data_mem[{line_idx, fill_cnt_q}] <= refill.beat_data;   // beats come in address order
    end
  end

  // beats only arrive for the line under refill
  a_beat_in_refill: assert property (@(posedge clk) disable iff (!rst_n)
    refill.beat_valid |-> state_q == REFILL);

  // master delivered a full line before signalling done
  a_fill_done_full: assert property (@(posedge clk) disable iff (!rst_n)
    refill.fill_done |-> (state_q == REFILL) && (fill_cnt_q == '0));

endmodule

/* source/axi_refill_master.sv */
`timescale 1ns/10ps
`include "fetch_config.svh"

module axi_refill_master (
  input  logic                   clk,
  input  logic                   rst_n,
  refill_if.master               refill,
  output logic                   ar_valid_o,
  input  logic                   ar_ready_i,
  output logic [63:0]            ar_addr_o,
  output axi_rd_pkg::axi_id_t    ar_id_o,
  output axi_rd_pkg::axi_len_t   ar_len_o,
  output axi_rd_pkg::axi_size_t  ar_size_o,
  output axi_rd_pkg::axi_burst_t ar_burst_o,
  input  logic                   r_valid_i,
  output logic                   r_ready_o,
  input  logic [63:0]            r_data_i,
  input  axi_rd_pkg::axi_resp_t  r_resp_i,
  input  logic                   r_last_i
);
  import axi_rd_pkg::*;

  localparam axi_id_t REFILL_ID = 4'd1;   // instruction side id
  localparam axi_len_t BURST_LEN = axi_len_t'(`LINE_BEATS - 1);
  localparam axi_resp_t RESP_OKAY = 2'b00;

  refill_state_e state_q;
  refill_state_e state_d;
  logic [63:0]   addr_q;
  axi_len_t      beat_cnt_q;   // beats received in this burst
  logic          beat_hs;
  logic          done_q;

  assign beat_hs = r_valid_i & r_ready_o;

  always_comb begin
    state_d = state_q;
    case (state_q)
      AR_IDLE: if (refill.fill_req) state_d = AR_SEND;
      AR_SEND: if (ar_ready_i) state_d = R_RECV;
      R_RECV: if (beat_hs && r_last_i) state_d = AR_IDLE;   // burst ends on last
      default: state_d = AR_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= AR_IDLE;
      beat_cnt_q <= '0;
      done_q <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q <= beat_hs & r_last_i;   // fill_done one cycle after the last beat
      if (state_q == AR_SEND) begin
        beat_cnt_q <= '0;
      end else if (beat_hs) begin
        beat_cnt_q <= beat_cnt_q + 1'b1;
      end
    end
  end

  // line address held while AR waits
  always_ff @(posedge clk) begin
    if (state_q == AR_IDLE && refill.fill_req) begin
      addr_q <= refill.fill_addr;
    end
  end

  // AR channel
  assign ar_valid_o = (state_q == AR_SEND);
  assign ar_addr_o = addr_q;
  assign ar_id_o = REFILL_ID;
  assign ar_len_o = BURST_LEN;
  assign ar_size_o = AXI_SIZE_8B;
  assign ar_burst_o = AXI_BURST_INCR;

  // R channel ready for the whole burst
  assign r_ready_o = (state_q == R_RECV);
  assign refill.beat_valid = beat_hs;
  assign refill.beat_data = r_data_i;
  assign refill.fill_done = done_q;

  // a new line request only while no burst is in flight
  a_fill_req_idle: assert property (@(posedge clk) disable iff (!rst_n)
    refill.fill_req |-> state_q == AR_IDLE);

  // slave ends the burst exactly on the requested length without errors
  a_r_last_count: assert property (@(posedge clk) disable iff (!rst_n)
    beat_hs |-> (r_resp_i == RESP_OKAY) && (r_last_i == (beat_cnt_q == BURST_LEN)));

endmodule

/* source/if_stage.sv */
`timescale 1ns/10ps

module if_stage (
  input  logic                   clk,
  input  logic                   rst_n,
  // decode side
  input  logic                   redirect_i,
  input  fetch_pkg::pc_t         redirect_pc_i,
  input  logic                   stall_i,
  output fetch_pkg::inst_t       inst_o,
  output fetch_pkg::pc_t         pc_o,
  output logic                   inst_valid_o,
  // AXI read address
  output logic                   ar_valid_o,
  input  logic                   ar_ready_i,
  output logic [63:0]            ar_addr_o,
  output axi_rd_pkg::axi_id_t    ar_id_o,
  output axi_rd_pkg::axi_len_t   ar_len_o,
  output axi_rd_pkg::axi_size_t  ar_size_o,
  output axi_rd_pkg::axi_burst_t ar_burst_o,
  // AXI read data
  input  logic                   r_valid_i,
  output logic                   r_ready_o,
  input  logic [63:0]            r_data_i,
  input  axi_rd_pkg::axi_resp_t  r_resp_i,
  input  logic                   r_last_i
);

  fetch_req_if u_fetch_if ();
  refill_if    u_refill_if ();

  pc_gen u_pc_gen (
    .clk           (clk),
    .rst_n         (rst_n),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .stall_i       (stall_i),
    .inst_o        (inst_o),
    .pc_o          (pc_o),
    .inst_valid_o  (inst_valid_o),
    .fetch         (u_fetch_if)
  );

  i_cache u_i_cache (
    .clk    (clk),
    .rst_n  (rst_n),
    .fetch  (u_fetch_if),
    .refill (u_refill_if)
  );

  axi_refill_master u_axi_refill_master (
    .clk        (clk),
    .rst_n      (rst_n),
    .refill     (u_refill_if),
    .ar_valid_o (ar_valid_o),
    .ar_ready_i (ar_ready_i),
    .ar_addr_o  (ar_addr_o),
    .ar_id_o    (ar_id_o),
    .ar_len_o   (ar_len_o),
    .ar_size_o  (ar_size_o),
    .ar_burst_o (ar_burst_o),
    .r_valid_i  (r_valid_i),
    .r_ready_o  (r_ready_o),
    .r_data_i   (r_data_i),
    .r_resp_i   (r_resp_i),
    .r_last_i   (r_last_i)
  );

endmodule

/* verification/tb_axi_mem.sv */
`timescale 1ns/10ps

// AXI read slave, one burst at a time, random AR and R gaps
module tb_axi_mem (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   ar_valid_i,
  output logic                   ar_ready_o,
  input  logic [63:0]            ar_addr_i,
  input  axi_rd_pkg::axi_len_t   ar_len_i,
  output logic                   r_valid_o,
  input  logic                   r_ready_i,
  output logic [63:0]            r_data_o,
  output axi_rd_pkg::axi_resp_t  r_resp_o,
  output logic                   r_last_o
);
  import axi_rd_pkg::*;

  integer      seed;
  logic        busy;      // burst accepted, beats left
  logic        taken;     // beat handshake at the last edge
  logic [63:0] addr;
  logic [63:0] beat_addr;
  axi_len_t    len;
  axi_len_t    beat;

  // memory contents, one 32-bit word per 4-byte address
  function automatic logic [31:0] mem_word(input logic [63:0] a);
    mem_word = a[31:0] ^ 32'hA5A5_0000;
  endfunction

  initial begin
    seed = 32'hd447_2978;
    busy = 1'b0;
    taken = 1'b0;
    addr = '0;
    len = '0;
    beat = '0;
    ar_ready_o = 1'b0;
    r_valid_o = 1'b0;
    r_data_o = '0;
    r_resp_o = 2'b00;   // always OKAY
    r_last_o = 1'b0;
    forever begin
      @(posedge clk);
      taken = 1'b0;
      if (!rst_n) begin
        busy = 1'b0;
      end else if (ar_valid_i && ar_ready_o) begin
        busy = 1'b1;
        addr = ar_addr_i;
        len = ar_len_i;
        beat = '0;
      end else if (r_valid_o && r_ready_i) begin
        taken = 1'b1;
        if (beat == len) begin
          busy = 1'b0;   // last beat gone
        end else begin
          beat = beat + 1'b1;
        end
      end
      @(negedge clk);
      ar_ready_o = rst_n && !busy && ({$random(seed)} % 3 != 0);
      if (!busy) begin
        r_valid_o = 1'b0;
      end else if (!(r_valid_o && !taken)) begin
        r_valid_o = ({$random(seed)} % 3 != 0);   // gap or beat, held once shown
      end
      beat_addr = addr + {beat, 3'b000};
      r_data_o = {mem_word(beat_addr + 64'd4), mem_word(beat_addr)};
      r_last_o = busy && (beat == len);
    end
  end

endmodule

/* verification/tb_if_stage.sv */
`timescale 1ns/10ps
`include "fetch_config.svh"

module tb_if_stage;
  import fetch_pkg::*;
  import axi_rd_pkg::*;

  logic       clk;
  logic       rst_n;
  logic       redirect_i;
  pc_t        redirect_pc_i;
  logic       stall_i;
  inst_t      inst_o;
  pc_t        pc_o;
  logic       inst_valid_o;
  logic       ar_valid_o;
  logic       ar_ready_i;
  logic [63:0] ar_addr_o;
  axi_id_t    ar_id_o;
  axi_len_t   ar_len_o;
  axi_size_t  ar_size_o;
  axi_burst_t ar_burst_o;
  logic       r_valid_i;
  logic       r_ready_o;
  logic [63:0] r_data_i;
  axi_resp_t  r_resp_i;
  logic       r_last_i;

  integer      seed;
  logic        stall_en;
  int          acc_count;     // accepted instructions so far
  pc_t         exp_pc;
  pc_t         first_pc;
  logic        hold_q;        // shown instruction was stalled at the last edge
  inst_t       hold_inst;
  pc_t         hold_pc;
  logic        ar_wait_q;     // AR was waiting for ready at the last edge
  logic [63:0] ar_wait_addr;
  axi_id_t     first_id;
  logic [63:0] ar_log[$];     // every AR address handed to the slave
  int          ar_before;
  int          n_hit;

  if_stage i_dut (.*);

  tb_axi_mem u_mem (
    .clk        (clk),
    .rst_n      (rst_n),
    .ar_valid_i (ar_valid_o),
    .ar_ready_o (ar_ready_i),
    .ar_addr_i  (ar_addr_o),
    .ar_len_i   (ar_len_o),
    .r_valid_o  (r_valid_i),
    .r_ready_i  (r_ready_o),
    .r_data_o   (r_data_i),
    .r_resp_o   (r_resp_i),
    .r_last_o   (r_last_i)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // expected memory word at a 4-byte address
  function automatic inst_t ref_inst(input pc_t pc);
    ref_inst = pc[31:0] ^ 32'hA5A5_0000;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
      $display("RESULT: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout at %0t: %s did not happen in time", $time, what);
    $display("RESULT: FAIL");
    $fatal(1, "timeout");
  endtask

  // one cycle of stimulus driven on the falling edge
  task automatic step();
    @(negedge clk);
    redirect_i = 1'b0;
    stall_i = stall_en ? ({$random(seed)} % 4 == 0) : 1'b0;
  endtask

  task automatic wait_accepts(input int n, input int limit);
    int target;
    int cycles;
    target = acc_count + n;
    cycles = 0;
    while (acc_count < target) begin
      step();
      cycles++;
      if (cycles > limit) report_timeout("instruction accept");
    end
  endtask

  task automatic wait_refill(input int limit);
    int cycles;
    cycles = 0;
    while (!r_ready_o) begin
      step();
      cycles++;
      if (cycles > limit) report_timeout("refill start");
    end
  endtask

  task automatic do_redirect(input pc_t target);
    step();
    redirect_i = 1'b1;
    redirect_pc_i = target;
  endtask

  // compare process sampling everything at the rising edge
  always @(posedge clk) begin
    if (rst_n) begin
      if (hold_q) begin
        check_value("inst_valid_o", inst_valid_o, 1'b1);
        check_value("inst_o", inst_o, hold_inst);   // must not move under stall
        check_value("pc_o", pc_o, hold_pc);
      end
      if (ar_wait_q) begin
        check_value("ar_valid_o", ar_valid_o, 1'b1);   // no withdraw before ready
        check_value("ar_addr_o", ar_addr_o, ar_wait_addr);
      end
      if (ar_valid_o && ar_ready_i) begin
        if (ar_log.size() == 0) first_id = ar_id_o;
        check_value("ar_id_o", ar_id_o, first_id);   // one fixed id for all bursts
        check_value("ar_addr_o line offset", ar_addr_o % (`LINE_BEATS * 8), 64'd0);
        check_value("ar_len_o", ar_len_o, `LINE_BEATS - 1);
        check_value("ar_size_o", ar_size_o, 3'b011);   // 8 bytes per beat
        check_value("ar_burst_o", ar_burst_o, 2'b01);   // INCR
        ar_log.push_back(ar_addr_o);
      end
      if (r_valid_i) check_value("r_ready_o", r_ready_o, 1'b1);   // ready through the burst
      if (redirect_i) begin
        exp_pc = redirect_pc_i;
      end else if (inst_valid_o && !stall_i) begin
        check_value("pc_o", pc_o, exp_pc);
        check_value("inst_o", inst_o, ref_inst(pc_o));
        if (acc_count == 0) first_pc = pc_o;
        acc_count++;
        exp_pc = pc_o + 64'd4;
      end
      hold_q = inst_valid_o && stall_i && !redirect_i;
      hold_inst = inst_o;
      hold_pc = pc_o;
      ar_wait_q = ar_valid_o && !ar_ready_i;
      ar_wait_addr = ar_addr_o;
    end
  end

  initial begin
    seed = 32'hd447_2978;
    rst_n = 1'b0;
    redirect_i = 1'b0;
    redirect_pc_i = '0;
    stall_i = 1'b0;
    stall_en = 1'b0;
    acc_count = 0;
    exp_pc = `RESET_PC;
    first_pc = '0;
    hold_q = 1'b0;
    hold_inst = '0;
    hold_pc = '0;
    ar_wait_q = 1'b0;
    ar_wait_addr = '0;
    first_id = '0;
    repeat (10) begin
      @(negedge clk);
      check_value("inst_valid_o", inst_valid_o, 1'b0);
      check_value("ar_valid_o", ar_valid_o, 1'b0);
      check_value("r_ready_o", r_ready_o, 1'b0);
    end
    check_value("pc_o", pc_o, `RESET_PC);
    rst_n = 1'b1;
    stall_en = 1'b1;

    // straight run over four cold lines
    wait_accepts(32, 5000);
    check_value("first pc_o", first_pc, `RESET_PC);
    n_hit = 0;
    foreach (ar_log[i]) begin
      if (ar_log[i] >= `RESET_PC && ar_log[i] < `RESET_PC + 64'd128) n_hit++;
    end
    check_value("AR count for first lines", n_hit, 4);

    // second pass over the resident lines
    ar_before = ar_log.size();
    do_redirect(`RESET_PC);
    wait_accepts(32, 5000);
    n_hit = 0;
    for (int i = ar_before; i < ar_log.size(); i++) begin
      if (ar_log[i] >= `RESET_PC && ar_log[i] < `RESET_PC + 64'd128) n_hit++;
    end
    check_value("AR count on second pass", n_hit, 0);

    // random redirects with odd rounds hitting a refill in flight
    for (int i = 0; i < 24; i++) begin
      repeat ({$random(seed)} % 16) step();
      do_redirect(`RESET_PC + 64'h1_0000 + (i * 64'h1000) + (({$random(seed)} % 256) * 4));
      if (i % 2 == 1) begin
        wait_refill(500);   // fresh region so always a miss
        do_redirect(`RESET_PC + (({$random(seed)} % 1024) * 4));
      end
      wait_accepts(1 + {$random(seed)} % 8, 5000);
    end

    stall_en = 1'b0;
    wait_accepts(8, 5000);
    $display("accepted %0d instructions, %0d AR bursts", acc_count, ar_log.size());
    $display("RESULT: PASS");
    $finish;
  end

endmodule

/* list.f */
+incdir+include
source/fetch_pkg.sv
source/axi_rd_pkg.sv
source/fetch_ifs.sv
source/pc_gen.sv
source/i_cache.sv
source/axi_refill_master.sv
source/if_stage.sv
verification/tb_axi_mem.sv
verification/tb_if_stage.sv

/* Makefile */
# Verilator build and run of the fetch stage testbench

OBJ_DIR = obj_dir

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f list.f \
		--top-module tb_if_stage --Mdir $(OBJ_DIR) -o sim

run: build
	./$(OBJ_DIR)/sim

lint:
	verilator --lint-only --timing -f list.f --top-module if_stage

clean:
	rm -rf $(OBJ_DIR)
